/* rv64_decoder.f */
+incdir+.
rv64_decode_pkg.sv
decode_if.sv
int_decoder.sv
mem_decoder.sv
flow_decoder.sv
decode_stage.sv
rv64_decoder.sv
tb_rv64_decoder.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f rv64_decoder.f \
    --top-module tb_rv64_decoder -o sim_rv64_decoder

# the log decides the result, so a nonzero exit of the run is not fatal here
./obj_dir/sim_rv64_decoder > sim.log 2>&1 || true
cat sim.log

if grep -q "RESULT: FAIL" sim.log || ! grep -q "RESULT: PASS" sim.log; then
    exit 1
fi

/* decode_model.svh */
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

typedef struct packed {
    logic [OP_W-1:0]       op;
    logic [ALU_W-1:0]      alufunc;
    logic                  regwrite;
    logic                  memread;
    logic                  memwrite;
    logic                  branch;
    logic                  nop;
    logic [REG_ADDR_W-1:0] ra1;
    logic [REG_ADDR_W-1:0] ra2;
} ctl_t;

// expected control word, written from the ISA encodings of each row
function automatic ctl_t decode_ref(input logic [31:0] w);
    ctl_t       c;
    logic [9:0] f7_f3;
    logic [2:0] f3;
    logic [5:0] f6;
    logic       rd_rs1;
    logic       rd_rs2;
    f3     = w[14:12];
    f7_f3  = {w[31:25], f3};
    f6     = w[31:26]; // shift immediates keep shamt[5] below this field
    rd_rs1 = 1'b0;
    rd_rs2 = 1'b0;
    c      = '0;
    c.op   = OP_UNKNOWN;
    case (w[6:0])
    OPC_OP_IMM:
    begin
        c.regwrite = 1'b1;
        rd_rs1     = 1'b1;
        case (f3)
        3'b000: {c.op, c.alufunc} = {OP_ADDI, ALU_ADD};
        3'b010: {c.op, c.alufunc} = {OP_SLTI, ALU_SLT};
        3'b011: {c.op, c.alufunc} = {OP_SLTIU, ALU_SLTU};
        3'b100: {c.op, c.alufunc} = {OP_XORI, ALU_XOR};
        3'b110: {c.op, c.alufunc} = {OP_ORI, ALU_OR};
        3'b111: {c.op, c.alufunc} = {OP_ANDI, ALU_AND};
        3'b001:
            if (f6 == 6'b000000)
                {c.op, c.alufunc} = {OP_SLLI, ALU_SLL};
        default:
            if (f6 == 6'b000000)
                {c.op, c.alufunc} = {OP_SRLI, ALU_SRL};
            else if (f6 == 6'b010000)
                {c.op, c.alufunc} = {OP_SRAI, ALU_SRA};
        endcase
    end
    OPC_OP:
    begin
        c.regwrite = 1'b1;
        rd_rs1     = 1'b1;
        rd_rs2     = 1'b1;
        case (f7_f3)
        10'b0000000_000: {c.op, c.alufunc} = {OP_ADD, ALU_ADD};
        10'b0100000_000: {c.op, c.alufunc} = {OP_SUB, ALU_SUB};
        10'b0000000_001: {c.op, c.alufunc} = {OP_SLL, ALU_SLL};
        10'b0000000_010: {c.op, c.alufunc} = {OP_SLT, ALU_SLT};
        10'b0000000_011: {c.op, c.alufunc} = {OP_SLTU, ALU_SLTU};
        10'b0000000_100: {c.op, c.alufunc} = {OP_XOR, ALU_XOR};
        10'b0000000_101: {c.op, c.alufunc} = {OP_SRL, ALU_SRL};
        10'b0100000_101: {c.op, c.alufunc} = {OP_SRA, ALU_SRA};
        10'b0000000_110: {c.op, c.alufunc} = {OP_OR, ALU_OR};
        10'b0000000_111: {c.op, c.alufunc} = {OP_AND, ALU_AND};
        default: ;
        endcase
    end
    OPC_OP_IMM_32:
    begin
        c.regwrite = 1'b1;
        rd_rs1     = 1'b1;
        if (f3 == 3'b000)
            {c.op, c.alufunc} = {OP_ADDIW, ALU_ADDW};
        else if (f3 == 3'b001 && f6 == 6'b000000)
            {c.op, c.alufunc} = {OP_SLLIW, ALU_SLLW};
        else if (f3 == 3'b101 && f6 == 6'b000000)
            {c.op, c.alufunc} = {OP_SRLIW, ALU_SRLW};
        else if (f3 == 3'b101 && f6 == 6'b010000)
            {c.op, c.alufunc} = {OP_SRAIW, ALU_SRAW};
    end
    OPC_OP_32:
    begin
        c.regwrite = 1'b1;
        rd_rs1     = 1'b1;
        rd_rs2     = 1'b1;
        case (f7_f3)
        10'b0000000_000: {c.op, c.alufunc} = {OP_ADDW, ALU_ADDW};
        10'b0100000_000: {c.op, c.alufunc} = {OP_SUBW, ALU_SUBW};
        10'b0000000_001: {c.op, c.alufunc} = {OP_SLLW, ALU_SLLW};
        10'b0000000_101: {c.op, c.alufunc} = {OP_SRLW, ALU_SRLW};
        10'b0100000_101: {c.op, c.alufunc} = {OP_SRAW, ALU_SRAW};
        default: ;
        endcase
    end
    OPC_LUI:   {c.op, c.regwrite} = {OP_LUI, 1'b1};
    OPC_AUIPC: {c.op, c.regwrite} = {OP_AUIPC, 1'b1};
    OPC_LOAD:
    begin
        {c.memread, c.regwrite} = 2'b11;
        rd_rs1                  = 1'b1;
        if (f3 != 3'b111)
            c.op = OP_LB + OP_W'(f3); // lb lh lw ld lbu lhu lwu in funct3 order
    end
    OPC_STORE:
    begin
        c.memwrite = 1'b1;
        rd_rs1     = 1'b1;
        rd_rs2     = 1'b1;
        if (!f3[2])
            c.op = OP_SB + OP_W'(f3);
    end
    OPC_BRANCH:
    begin
        {c.branch, c.alufunc} = {1'b1, ALU_CMP};
        rd_rs1                = 1'b1;
        rd_rs2                = 1'b1;
        case (f3)
        3'b000: c.op = OP_BEQ;
        3'b001: c.op = OP_BNE;
        3'b100: c.op = OP_BLT;
        3'b101: c.op = OP_BGE;
        3'b110: c.op = OP_BLTU;
        3'b111: c.op = OP_BGEU;
        default: ;
        endcase
    end
    OPC_JAL: {c.op, c.alufunc, c.branch, c.regwrite} = {OP_JAL, ALU_LINK, 2'b11};
    OPC_JALR:
    begin
        {c.alufunc, c.branch, c.regwrite} = {ALU_LINK, 2'b11};
        rd_rs1                            = 1'b1;
        if (f3 == 3'b000)
            c.op = OP_JALR;
    end
    default: ;
    endcase
    if (w == '0)
    begin
        c     = '0;
        c.op  = OP_NOP;
        c.nop = 1'b1;
    end
    else if (c.op == OP_UNKNOWN)
    begin
        c    = '0; // unmatched words carry no flags and no addresses
        c.op = OP_UNKNOWN;
    end
    else
    begin
        c.ra1 = rd_rs1 ? w[19:15] : '0;
        c.ra2 = rd_rs2 ? w[24:20] : '0;
    end
    return c;
endfunction

function automatic logic [31:0] build_int_word();
    logic [31:0] w;
    w = $urandom;
    case ($urandom % 6)
    0: w[6:0] = OPC_OP_IMM;
    1: w[6:0] = OPC_OP;
    2: w[6:0] = OPC_OP_IMM_32;
    3: w[6:0] = OPC_OP_32;
    4: w[6:0] = OPC_LUI;
    default: w[6:0] = OPC_AUIPC;
    endcase
    // mostly a legal upper field so that most words hit a row
    if ($urandom % 8 != 0)
        w[31:25] = ($urandom % 2 != 0) ? 7'b0100000 : 7'b0000000;
    return w;
endfunction

function automatic logic [31:0] build_mem_word();
    logic [31:0] w;
    w = $urandom;
    if ($urandom % 2 != 0)
    begin
        w[6:0]   = OPC_LOAD;
        w[14:12] = 3'($urandom % 7);
    end
    else
    begin
        w[6:0]   = OPC_STORE;
        w[14:12] = 3'($urandom % 4);
    end
    return w;
endfunction

function automatic logic [31:0] build_flow_word();
    logic [31:0] w;
    logic [2:0]  f3;
    w  = $urandom;
    f3 = 3'($urandom % 6);
    if (f3 > 3'd1)
        f3 = f3 + 3'd2; // skip the two unused branch encodings
    case ($urandom % 4)
    0, 1:
    begin
        w[6:0]   = OPC_BRANCH;
        w[14:12] = f3;
    end
    2: w[6:0] = OPC_JAL;
    default:
    begin
        w[6:0]   = OPC_JALR;
        w[14:12] = 3'b000;
    end
    endcase
    return w;
endfunction

function automatic logic [31:0] build_any_word();
    logic [31:0] w;
    case ($urandom % 4)
    0: w = build_int_word();
    1: w = build_mem_word();
    2: w = build_flow_word();
    default: w = $urandom;
    endcase
    return w;
endfunction

`endif

/* tb_rv64_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rv64_decoder;
    import rv64_decode_pkg::*;

    `include "decode_model.svh"

    typedef struct packed {
        logic valid;
        ctl_t ctl;
    } exp_t;

    localparam int SEED     = 6341;
    localparam int N_STROBE = 200;
    localparam int MAX_GAP  = 3;
    // every issue and drain takes one cycle, plus reset and slack
    localparam int RUN_CYCLES  = 5 + 302 + 201 + 201 + 301 + N_STROBE * (MAX_GAP + 1) + 1;
    localparam int WATCHDOG_NS = RUN_CYCLES * 8 + 500;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  instr_valid;
    logic [INSTR_W-1:0]    instr;
    logic                  ctl_valid;
    logic                  regwrite;
    logic                  memread;
    logic                  memwrite;
    logic                  branch;
    logic                  nop;
    logic [OP_W-1:0]       op;
    logic [ALU_W-1:0]      alufunc;
    logic [REG_ADDR_W-1:0] ra1;
    logic [REG_ADDR_W-1:0] ra2;

    exp_t exp_q[$]; // holds at most the one word in the output register
    ctl_t held;     // last valid control word, kept by the outputs through gaps
    int   checks = 0;
    int   errors = 0;
    int   test_checks0;
    int   test_errors0;

    always #4 clk = ~clk;

    rv64_decoder i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .ctl_valid   (ctl_valid),
        .regwrite    (regwrite),
        .memread     (memread),
        .memwrite    (memwrite),
        .branch      (branch),
        .nop         (nop),
        .op          (op),
        .alufunc     (alufunc),
        .ra1         (ra1),
        .ra2         (ra2)
    );

    task automatic compare_field(input string name, input logic [7:0] exp_v,
                                 input logic [7:0] act_v);
        checks++;
        assert (act_v === exp_v)
        else
        begin
            $display("Mismatch at %0t ns: %s expected 0x%0h got 0x%0h",
                     $time, name, exp_v, act_v);
            errors++;
        end
    endtask

    task automatic check_outputs(input exp_t e);
        compare_field("ctl_valid", 8'(e.valid), 8'(ctl_valid));
        compare_field("op", 8'(e.ctl.op), 8'(op));
        compare_field("alufunc", 8'(e.ctl.alufunc), 8'(alufunc));
        compare_field("regwrite", 8'(e.ctl.regwrite), 8'(regwrite));
        compare_field("memread", 8'(e.ctl.memread), 8'(memread));
        compare_field("memwrite", 8'(e.ctl.memwrite), 8'(memwrite));
        compare_field("branch", 8'(e.ctl.branch), 8'(branch));
        compare_field("nop", 8'(e.ctl.nop), 8'(nop));
        compare_field("ra1", 8'(e.ctl.ra1), 8'(ra1));
        compare_field("ra2", 8'(e.ctl.ra2), 8'(ra2));
    endtask

    // outputs from the previous edge are stable 1 ns after it
    task automatic issue(input logic valid, input logic [31:0] word);
        exp_t e;
        exp_t prev;
        @(posedge clk);
        #1;
        if (exp_q.size() > 0)
        begin
            prev = exp_q.pop_front();
            check_outputs(prev);
        end
        instr_valid = valid;
        instr       = word;
        if (valid)
            held = decode_ref(word);
        e.valid     = valid;
        e.ctl       = held;
        exp_q.push_back(e);
    endtask

    task automatic drain();
        exp_t prev;
        @(posedge clk);
        #1;
        if (exp_q.size() > 0)
        begin
            prev = exp_q.pop_front();
            check_outputs(prev);
        end
        instr_valid = 1'b0;
    endtask

    task automatic start_test();
        test_checks0 = checks;
        test_errors0 = errors;
    endtask

    task automatic finish_test(input string name);
        $display("test %s: %0d checks, %0d errors", name, checks - test_checks0,
                 errors - test_errors0);
    endtask

    initial
    begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("RESULT: FAIL");
        $finish;
    end

    initial
    begin
        void'($urandom(SEED));
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;

        start_test();
        compare_field("ctl_valid", 8'h00, 8'(ctl_valid));
        compare_field("regwrite", 8'h00, 8'(regwrite));
        compare_field("memread", 8'h00, 8'(memread));
        compare_field("memwrite", 8'h00, 8'(memwrite));
        compare_field("branch", 8'h00, 8'(branch));
        compare_field("nop", 8'h00, 8'(nop));
        finish_test("reset");

        start_test();
        issue(1'b1, 32'h0000_0000);
        repeat (300) issue(1'b1, build_int_word());
        drain();
        finish_test("integer classes");

        start_test();
        repeat (200) issue(1'b1, build_mem_word());
        drain();
        finish_test("memory classes");

        start_test();
        repeat (200) issue(1'b1, build_flow_word());
        drain();
        finish_test("control flow");

        start_test();
        repeat (300) issue(1'b1, $urandom);
        drain();
        finish_test("illegal encodings");

        start_test();
        repeat (N_STROBE)
        begin
            repeat ($urandom % (MAX_GAP + 1)) issue(1'b0, $urandom);
            issue(1'b1, build_any_word());
        end
        drain();
        finish_test("valid strobe");

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* rv64_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module rv64_decoder (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  instr_valid,
    input  logic [rv64_decode_pkg::INSTR_W-1:0]    instr,
    output logic                                  ctl_valid,
    output logic                                  regwrite,
    output logic                                  memread,
    output logic                                  memwrite,
    output logic                                  branch,
    output logic                                  nop,
    output logic [rv64_decode_pkg::OP_W-1:0]       op,
    output logic [rv64_decode_pkg::ALU_W-1:0]      alufunc,
    output logic [rv64_decode_pkg::REG_ADDR_W-1:0] ra1,
    output logic [rv64_decode_pkg::REG_ADDR_W-1:0] ra2
);
    import rv64_decode_pkg::*;

    instr_u instr_w;

    decode_if int_res ();
    decode_if mem_res ();
    decode_if flow_res ();

    assign instr_w = instr_u'(instr);

    int_decoder i_int_dec (
        .instr (instr_w),
        .res   (int_res)
    );

    mem_decoder i_mem_dec (
        .instr (instr_w),
        .res   (mem_res)
    );

    flow_decoder i_flow_dec (
        .instr (instr_w),
        .res   (flow_res)
    );

    decode_stage i_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .int_res     (int_res),
        .mem_res     (mem_res),
        .flow_res    (flow_res),
        .ctl_valid   (ctl_valid),
        .regwrite    (regwrite),
        .memread     (memread),
        .memwrite    (memwrite),
        .branch      (branch),
        .nop         (nop),
        .op          (op),
        .alufunc     (alufunc),
        .ra1         (ra1),
        .ra2         (ra2)
    );

endmodule

`default_nettype wire

/* decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  instr_valid,
    decode_if.dst                                 int_res,
    decode_if.dst                                 mem_res,
    decode_if.dst                                 flow_res,
    output logic                                  ctl_valid,
    output logic                                  regwrite,
    output logic                                  memread,
    output logic                                  memwrite,
    output logic                                  branch,
    output logic                                  nop,
    output logic [rv64_decode_pkg::OP_W-1:0]       op,
    output logic [rv64_decode_pkg::ALU_W-1:0]      alufunc,
    output logic [rv64_decode_pkg::REG_ADDR_W-1:0] ra1,
    output logic [rv64_decode_pkg::REG_ADDR_W-1:0] ra2
);
    import rv64_decode_pkg::*;

    logic [CTL_W-1:0] int_word;
    logic [CTL_W-1:0] mem_word;
    logic [CTL_W-1:0] flow_word;
    logic [CTL_W-1:0] sel_word;

    // payload fields sit above the five flags in the low bits
    assign int_word  = {int_res.op, int_res.alufunc, int_res.ra1, int_res.ra2,
                        int_res.regwrite, int_res.memread, int_res.memwrite,
                        int_res.branch, int_res.nop};
    assign mem_word  = {mem_res.op, mem_res.alufunc, mem_res.ra1, mem_res.ra2,
                        mem_res.regwrite, mem_res.memread, mem_res.memwrite,
                        mem_res.branch, mem_res.nop};
    assign flow_word = {flow_res.op, flow_res.alufunc, flow_res.ra1, flow_res.ra2,
                        flow_res.regwrite, flow_res.memread, flow_res.memwrite,
                        flow_res.branch, flow_res.nop};

    always_comb
    begin
        if (int_res.hit)
            sel_word = int_word;
        else if (mem_res.hit)
            sel_word = mem_word;
        else if (flow_res.hit)
            sel_word = flow_word;
        else
            sel_word = {OP_UNKNOWN, {(CTL_W - OP_W){1'b0}}}; // no class matched
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            ctl_valid <= 1'b0;
            {regwrite, memread, memwrite, branch, nop} <= '0;
        end
        else
        begin
            ctl_valid <= instr_valid;
            if (instr_valid)
                {regwrite, memread, memwrite, branch, nop} <= sel_word[4:0];
        end
    end

    always_ff @(posedge clk)
    begin
        if (instr_valid)
            {op, alufunc, ra1, ra2} <= sel_word[CTL_W-1:5];
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        instr_valid |-> $onehot0({int_res.hit, mem_res.hit, flow_res.hit}))
        else $error("more than one decoder claimed the instruction");

    // a load and a store never share one control word
    assert property (@(posedge clk) disable iff (!rst_n)
        ctl_valid |-> !(memread && memwrite))
        else $error("registered control word has memread and memwrite both set");

endmodule

`default_nettype wire

/* flow_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module flow_decoder (
    input  rv64_decode_pkg::instr_u instr,
    decode_if.src                   res
);
    import rv64_decode_pkg::*;

    logic [OP_W-1:0] op_d;
    logic            is_jump;

    always_comb
    begin
        op_d = OP_UNKNOWN;
        case (instr.r.opcode)
        OPC_BRANCH:
            case (instr.r.funct3)
            F3_BEQ:  op_d = OP_BEQ;
            F3_BNE:  op_d = OP_BNE;
            F3_BLT:  op_d = OP_BLT;
            F3_BGE:  op_d = OP_BGE;
            F3_BLTU: op_d = OP_BLTU;
            F3_BGEU: op_d = OP_BGEU;
            default: op_d = OP_UNKNOWN;
            endcase
        OPC_JAL: op_d = OP_JAL;
        OPC_JALR:
            if (instr.i.funct3 == F3_JALR)
                op_d = OP_JALR;
        default: ;
        endcase
    end

    assign is_jump = op_d == OP_JAL || op_d == OP_JALR;

    assign res.hit      = op_d != OP_UNKNOWN;
    assign res.op       = op_d;
    assign res.alufunc  = is_jump ? ALU_LINK : ALU_CMP;
    assign res.regwrite = is_jump; // jumps write the link register
    assign res.memread  = 1'b0;
    assign res.memwrite = 1'b0;
    assign res.branch   = res.hit;
    assign res.nop      = 1'b0;
    // JAL targets are pc relative and read no register
    assign res.ra1      = (res.hit && op_d != OP_JAL) ? instr.r.rs1 : '0;
    assign res.ra2      = (res.hit && !is_jump) ? instr.r.rs2 : '0;

endmodule

`default_nettype wire

/* mem_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_decoder (
    input  rv64_decode_pkg::instr_u instr,
    decode_if.src                   res
);
    import rv64_decode_pkg::*;

    logic [OP_W-1:0] op_d;
    logic            is_store;

    always_comb
    begin
        op_d = OP_UNKNOWN;
        case (instr.r.opcode)
        OPC_LOAD:
            case (instr.i.funct3)
            F3_LB:   op_d = OP_LB;
            F3_LH:   op_d = OP_LH;
            F3_LW:   op_d = OP_LW;
            F3_LD:   op_d = OP_LD;
            F3_LBU:  op_d = OP_LBU;
            F3_LHU:  op_d = OP_LHU;
            F3_LWU:  op_d = OP_LWU;
            default: op_d = OP_UNKNOWN;
            endcase
        OPC_STORE:
            case (instr.r.funct3)
            F3_SB:   op_d = OP_SB;
            F3_SH:   op_d = OP_SH;
            F3_SW:   op_d = OP_SW;
            F3_SD:   op_d = OP_SD;
            default: op_d = OP_UNKNOWN;
            endcase
        default: ;
        endcase
    end

    assign is_store = instr.r.opcode == OPC_STORE;

    assign res.hit      = op_d != OP_UNKNOWN;
    assign res.op       = op_d;
    assign res.alufunc  = ALU_ADD;  // address is base plus offset
    assign res.memread  = res.hit && !is_store;
    assign res.memwrite = res.hit && is_store;
    assign res.regwrite = res.memread;
    assign res.branch   = 1'b0;
    assign res.nop      = 1'b0;
    assign res.ra1      = res.hit ? instr.r.rs1 : '0;
    assign res.ra2      = res.memwrite ? instr.r.rs2 : '0; // loads carry no store data

endmodule

`default_nettype wire

/* int_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module int_decoder (
    input  rv64_decode_pkg::instr_u instr,
    decode_if.src                   res
);
    import rv64_decode_pkg::*;

    logic [OP_W-1:0]  op_d;
    logic [ALU_W-1:0] alu_d;
    logic             rs1_en;
    logic             rs2_en;
    logic [5:0]       sh_hi;

    assign sh_hi = instr.i.imm12[11:6]; // upper field of the 64-bit shift immediates

    always_comb
    begin
        op_d   = OP_UNKNOWN;
        alu_d  = ALU_ADD;
        rs1_en = 1'b0;
        rs2_en = 1'b0;
        if (instr == '0)
            op_d = OP_NOP;
        else
        begin
            case (instr.r.opcode)
            OPC_OP_IMM:
            begin
                rs1_en = 1'b1;
                case (instr.i.funct3)
                F3_ADD:  {op_d, alu_d} = {OP_ADDI, ALU_ADD};
                F3_SLT:  {op_d, alu_d} = {OP_SLTI, ALU_SLT};
                F3_SLTU: {op_d, alu_d} = {OP_SLTIU, ALU_SLTU};
                F3_XOR:  {op_d, alu_d} = {OP_XORI, ALU_XOR};
                F3_OR:   {op_d, alu_d} = {OP_ORI, ALU_OR};
                F3_AND:  {op_d, alu_d} = {OP_ANDI, ALU_AND};
                F3_SLL:
                    if (sh_hi == F6_BASE)
                        {op_d, alu_d} = {OP_SLLI, ALU_SLL};
                F3_SRL:
                    if (sh_hi == F6_BASE)
                        {op_d, alu_d} = {OP_SRLI, ALU_SRL};
                    else if (sh_hi == F6_ALT)
                        {op_d, alu_d} = {OP_SRAI, ALU_SRA};
                default: ;
                endcase
            end
            OPC_OP:
            begin
                rs1_en = 1'b1;
                rs2_en = 1'b1;
                case ({instr.r.funct7, instr.r.funct3})
                {F7_BASE, F3_ADD}:  {op_d, alu_d} = {OP_ADD, ALU_ADD};
                {F7_ALT, F3_ADD}:   {op_d, alu_d} = {OP_SUB, ALU_SUB};
                {F7_BASE, F3_SLL}:  {op_d, alu_d} = {OP_SLL, ALU_SLL};
                {F7_BASE, F3_SLT}:  {op_d, alu_d} = {OP_SLT, ALU_SLT};
                {F7_BASE, F3_SLTU}: {op_d, alu_d} = {OP_SLTU, ALU_SLTU};
                {F7_BASE, F3_XOR}:  {op_d, alu_d} = {OP_XOR, ALU_XOR};
                {F7_BASE, F3_SRL}:  {op_d, alu_d} = {OP_SRL, ALU_SRL};
                {F7_ALT, F3_SRL}:   {op_d, alu_d} = {OP_SRA, ALU_SRA};
                {F7_BASE, F3_OR}:   {op_d, alu_d} = {OP_OR, ALU_OR};
                {F7_BASE, F3_AND}:  {op_d, alu_d} = {OP_AND, ALU_AND};
                default: ;
                endcase
            end
            OPC_OP_IMM_32:
            begin
                rs1_en = 1'b1;
                case (instr.i.funct3)
                F3_ADD: {op_d, alu_d} = {OP_ADDIW, ALU_ADDW};
                F3_SLL:
                    if (sh_hi == F6_BASE)
                        {op_d, alu_d} = {OP_SLLIW, ALU_SLLW};
                F3_SRL:
                    if (sh_hi == F6_BASE)
                        {op_d, alu_d} = {OP_SRLIW, ALU_SRLW};
                    else if (sh_hi == F6_ALT)
                        {op_d, alu_d} = {OP_SRAIW, ALU_SRAW};
                default: ;
                endcase
            end
            OPC_OP_32:
            begin
                rs1_en = 1'b1;
                rs2_en = 1'b1;
                case ({instr.r.funct7, instr.r.funct3})
                {F7_BASE, F3_ADD}: {op_d, alu_d} = {OP_ADDW, ALU_ADDW};
                {F7_ALT, F3_ADD}:  {op_d, alu_d} = {OP_SUBW, ALU_SUBW};
                {F7_BASE, F3_SLL}: {op_d, alu_d} = {OP_SLLW, ALU_SLLW};
                {F7_BASE, F3_SRL}: {op_d, alu_d} = {OP_SRLW, ALU_SRLW};
                {F7_ALT, F3_SRL}:  {op_d, alu_d} = {OP_SRAW, ALU_SRAW};
                default: ;
                endcase
            end
            OPC_LUI:   op_d = OP_LUI; // upper immediates read no register
            OPC_AUIPC: op_d = OP_AUIPC;
            default: ;
            endcase
        end
    end

    assign res.hit      = op_d != OP_UNKNOWN;
    assign res.op       = op_d;
    assign res.alufunc  = alu_d;
    assign res.regwrite = res.hit && op_d != OP_NOP;
    assign res.memread  = 1'b0;
    assign res.memwrite = 1'b0;
    assign res.branch   = 1'b0;
    assign res.nop      = op_d == OP_NOP;
    assign res.ra1      = (res.hit && rs1_en) ? instr.r.rs1 : '0;
    assign res.ra2      = (res.hit && rs2_en) ? instr.r.rs2 : '0;

endmodule

`default_nettype wire

/* decode_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface decode_if;
    import rv64_decode_pkg::*;

    logic                  hit;
    logic [OP_W-1:0]       op;
    logic [ALU_W-1:0]      alufunc;
    logic                  regwrite;
    logic                  memread;
    logic                  memwrite;
    logic                  branch;
    logic                  nop;
    logic [REG_ADDR_W-1:0] ra1;
    logic [REG_ADDR_W-1:0] ra2;

    modport src (
        output hit, op, alufunc, regwrite, memread, memwrite, branch, nop, ra1, ra2
    );

    modport dst (
        input hit, op, alufunc, regwrite, memread, memwrite, branch, nop, ra1, ra2
    );

endinterface

`default_nettype wire

/* rv64_decode_pkg.sv */
`default_nettype none

package rv64_decode_pkg;

    localparam int INSTR_W    = 32;
    localparam int REG_ADDR_W = 5;
    localparam int OP_W       = 6;
    localparam int ALU_W      = 4;
    // op, alufunc, ra1, ra2 and the five flags as one merge word
    localparam int CTL_W      = OP_W + ALU_W + 2 * REG_ADDR_W + 5;

    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
    localparam logic [6:0] OPC_OP_32     = 7'b0111011;
    localparam logic [6:0] OPC_LUI       = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
    localparam logic [6:0] OPC_LOAD      = 7'b0000011;
    localparam logic [6:0] OPC_STORE     = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
    localparam logic [6:0] OPC_JAL       = 7'b1101111;
    localparam logic [6:0] OPC_JALR      = 7'b1100111;

    // integer rows, shared by the register and immediate forms
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SRL  = 3'b101; // SRA too, told apart by the upper field
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LD  = 3'b011;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;
    localparam logic [2:0] F3_LWU = 3'b110;

    localparam logic [2:0] F3_SB = 3'b000;
    localparam logic [2:0] F3_SH = 3'b001;
    localparam logic [2:0] F3_SW = 3'b010;
    localparam logic [2:0] F3_SD = 3'b011;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;
    localparam logic [2:0] F3_JALR = 3'b000;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;
    localparam logic [5:0] F6_BASE = 6'b000000;
    localparam logic [5:0] F6_ALT  = 6'b010000;

    localparam logic [OP_W-1:0] OP_NOP     = 6'd0;
    localparam logic [OP_W-1:0] OP_ADDI    = 6'd1;
    localparam logic [OP_W-1:0] OP_SLTI    = 6'd2;
    localparam logic [OP_W-1:0] OP_SLTIU   = 6'd3;
    localparam logic [OP_W-1:0] OP_XORI    = 6'd4;
    localparam logic [OP_W-1:0] OP_ORI     = 6'd5;
    localparam logic [OP_W-1:0] OP_ANDI    = 6'd6;
    localparam logic [OP_W-1:0] OP_SLLI    = 6'd7;
    localparam logic [OP_W-1:0] OP_SRLI    = 6'd8;
    localparam logic [OP_W-1:0] OP_SRAI    = 6'd9;
    localparam logic [OP_W-1:0] OP_ADD     = 6'd10;
    localparam logic [OP_W-1:0] OP_SUB     = 6'd11;
    localparam logic [OP_W-1:0] OP_SLL     = 6'd12;
    localparam logic [OP_W-1:0] OP_SLT     = 6'd13;
    localparam logic [OP_W-1:0] OP_SLTU    = 6'd14;
    localparam logic [OP_W-1:0] OP_XOR     = 6'd15;
    localparam logic [OP_W-1:0] OP_SRL     = 6'd16;
    localparam logic [OP_W-1:0] OP_SRA     = 6'd17;
    localparam logic [OP_W-1:0] OP_OR      = 6'd18;
    localparam logic [OP_W-1:0] OP_AND     = 6'd19;
    localparam logic [OP_W-1:0] OP_ADDIW   = 6'd20;
    localparam logic [OP_W-1:0] OP_SLLIW   = 6'd21;
    localparam logic [OP_W-1:0] OP_SRLIW   = 6'd22;
    localparam logic [OP_W-1:0] OP_SRAIW   = 6'd23;
    localparam logic [OP_W-1:0] OP_ADDW    = 6'd24;
    localparam logic [OP_W-1:0] OP_SUBW    = 6'd25;
    localparam logic [OP_W-1:0] OP_SLLW    = 6'd26;
    localparam logic [OP_W-1:0] OP_SRLW    = 6'd27;
    localparam logic [OP_W-1:0] OP_SRAW    = 6'd28;
    localparam logic [OP_W-1:0] OP_LUI     = 6'd29;
    localparam logic [OP_W-1:0] OP_AUIPC   = 6'd30;
    localparam logic [OP_W-1:0] OP_LB      = 6'd31;
    localparam logic [OP_W-1:0] OP_LH      = 6'd32;
    localparam logic [OP_W-1:0] OP_LW      = 6'd33;
    localparam logic [OP_W-1:0] OP_LD      = 6'd34;
    localparam logic [OP_W-1:0] OP_LBU     = 6'd35;
    localparam logic [OP_W-1:0] OP_LHU     = 6'd36;
    localparam logic [OP_W-1:0] OP_LWU     = 6'd37;
    localparam logic [OP_W-1:0] OP_SB      = 6'd38;
    localparam logic [OP_W-1:0] OP_SH      = 6'd39;
    localparam logic [OP_W-1:0] OP_SW      = 6'd40;
    localparam logic [OP_W-1:0] OP_SD      = 6'd41;
    localparam logic [OP_W-1:0] OP_BEQ     = 6'd42;
    localparam logic [OP_W-1:0] OP_BNE     = 6'd43;
    localparam logic [OP_W-1:0] OP_BLT     = 6'd44;
    localparam logic [OP_W-1:0] OP_BGE     = 6'd45;
    localparam logic [OP_W-1:0] OP_BLTU    = 6'd46;
    localparam logic [OP_W-1:0] OP_BGEU    = 6'd47;
    localparam logic [OP_W-1:0] OP_JAL     = 6'd48;
    localparam logic [OP_W-1:0] OP_JALR    = 6'd49;
    localparam logic [OP_W-1:0] OP_UNKNOWN = 6'd63;

    localparam logic [ALU_W-1:0] ALU_ADD  = 4'd0;
    localparam logic [ALU_W-1:0] ALU_SUB  = 4'd1;
    localparam logic [ALU_W-1:0] ALU_AND  = 4'd2;
    localparam logic [ALU_W-1:0] ALU_OR   = 4'd3;
    localparam logic [ALU_W-1:0] ALU_XOR  = 4'd4;
    localparam logic [ALU_W-1:0] ALU_SLL  = 4'd5;
    localparam logic [ALU_W-1:0] ALU_SRL  = 4'd6;
    localparam logic [ALU_W-1:0] ALU_SRA  = 4'd7;
    localparam logic [ALU_W-1:0] ALU_SLT  = 4'd8;
    localparam logic [ALU_W-1:0] ALU_SLTU = 4'd9;
    localparam logic [ALU_W-1:0] ALU_ADDW = 4'd10;
    localparam logic [ALU_W-1:0] ALU_SUBW = 4'd11;
    localparam logic [ALU_W-1:0] ALU_SLLW = 4'd12;
    localparam logic [ALU_W-1:0] ALU_SRLW = 4'd13;
    localparam logic [ALU_W-1:0] ALU_SRAW = 4'd14;
    localparam logic [ALU_W-1:0] ALU_CMP  = 4'd15;
    // the link value is pc + 4, so jumps share the adder code
    localparam logic [ALU_W-1:0] ALU_LINK = ALU_ADD;

    // one instruction word seen as R form or as I form
    typedef union packed {
        struct packed {
            logic [6:0]            funct7;
            logic [REG_ADDR_W-1:0] rs2;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } r;
        struct packed {
            logic [11:0]           imm12;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } i;
    } instr_u;

endpackage

`default_nettype wire
